/* fso_deframer.f */
dfr_pkg.sv
frame_sync.sv
crc32_check.sv
frame_result.sv
fso_deframer.sv
tb_fso_deframer_asserts.sv
tb_fso_deframer.sv

/* run.sh */
#!/bin/sh
# build with verilator, then look for the pass line in the simulation output
verilator --binary --timing --assert -Wno-fatal --top-module tb_fso_deframer \
    -f fso_deframer.f -o tb_sim \
    && ./obj_dir/tb_sim | tee /dev/stderr | grep -q "^PASS: all tests$" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

/* tb_fso_deframer.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fso_deframer
    import dfr_pkg::*;
();

    logic         clk;
    logic         rst_n;
    logic         i_link_up;
    word_t        i_s_data;
    logic         i_s_valid;
    logic         i_m_ready;
    logic         o_s_ready;
    word_t        o_m_data;
    logic         o_m_first;
    logic         o_m_valid;
    logic         o_frame_start;
    frame_hdr_t   o_hdr;
    logic [15:0]  o_frame_index;
    logic         o_frame_locked;
    frame_stats_t o_stats;

    logic [31:0] lfsr_q;
    string       cur_test;
    int          errors;
    int          test_errs;
    int          tests_run;
    int          hdr_count;
    int          exp_total;
    int          exp_errs;
    int          fs_count;
    bit          bp_en;
    bit          bp_pat [256];
    int          bp_idx;
    word_t       exp_data [$];
    bit          exp_first [$];
    word_t       rx_data [$];
    bit          rx_first [$];

    fso_deframer uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // ========================================
    // ready driver and output collector
    // ========================================

    always @(posedge clk) begin
        #1;
        if (bp_en) begin
            i_m_ready = bp_pat[bp_idx];
            bp_idx = (bp_idx + 1) % 256;
        end else begin
            i_m_ready = 1'b1;
        end
    end

    // sampled mid-cycle before the transfer edge
    always @(negedge clk) begin
        if (rst_n && o_m_valid && i_m_ready) begin
            rx_data.push_back(o_m_data);
            rx_first.push_back(o_m_first);
        end
        if (rst_n && o_frame_start) begin
            fs_count++;
        end
    end

    // ========================================
    // stimulus helpers and reference model
    // ========================================

    function automatic logic next_rand_bit();
        logic lsb;
        lsb = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (lsb) begin
            lfsr_q = lfsr_q ^ 32'h8020_0003;
        end
        return lsb;
    endfunction

    function automatic word_t rand_word();
        word_t w;
        w = '0;
        for (int i = 0; i < 32; i++) begin
            w = {w[30:0], next_rand_bit()};
        end
        return w;
    endfunction

    // bytewise crc-32 with msb first and no reflection
    function automatic logic [31:0] crc_add_word(input logic [31:0] crc, input word_t w);
        logic [31:0] c;
        c = crc;
        for (int b = 3; b >= 0; b--) begin
            c = c ^ {w[b*8 +: 8], 24'h0};
            for (int k = 0; k < 8; k++) begin
                c = c[31] ? ((c << 1) ^ CRC_POLY) : (c << 1);
            end
        end
        return c;
    endfunction

    task automatic check_eq(input string what, input logic [63:0] exp, input logic [63:0] act);
        assert (exp === act) else begin
            $display("Error: %s: %s expected %0h actual %0h", cur_test, what, exp, act);
            errors++;
            test_errs++;
        end
    endtask

    task automatic report_timeout(input string what);
        $display("%s: timed out waiting for %s", cur_test, what);
        errors++;
        test_errs++;
    endtask

    task automatic send_word(input word_t w);
        int  waited;
        bit  taken;
        waited = 0;
        taken = 1'b0;
        i_s_data = w;
        i_s_valid = 1'b1;
        while (!taken && waited < 200) begin
            @(negedge clk);
            taken = o_s_ready;
            @(posedge clk);
            #1;
            waited++;
        end
        i_s_valid = 1'b0;
        assert (taken) else report_timeout("the DUT to accept an input word");
    endtask

    // full frames end with a crc word and short ones stop after n_pay words
    task automatic send_frame(input frame_hdr_t hdr, input int n_pay, input bit bad_crc);
        word_t       w;
        logic [31:0] crc;
        crc = CRC_INIT;
        send_word(PREAMBLE_HI);
        send_word(PREAMBLE_LO);
        send_word(word_t'(hdr));
        hdr_count++;
        for (int i = 0; i < n_pay; i++) begin
            w = rand_word();
            crc = crc_add_word(crc, w);
            exp_data.push_back(w);
            exp_first.push_back(i == 0);
            send_word(w);
        end
        if (n_pay == PAYLOAD_WORDS) begin
            send_word(bad_crc ? (crc ^ 32'h1) : crc);
            exp_total++;
            if (bad_crc) begin
                exp_errs++;
            end
        end
    endtask

    task automatic wait_total(input logic [31:0] target);
        int waited;
        waited = 0;
        while (o_stats.total_frames != target && waited < 1000) begin
            @(posedge clk);
            #1;
            waited++;
        end
        assert (o_stats.total_frames == target)
            else report_timeout("the frame counter to advance");
    endtask

    task automatic check_stream();
        check_eq("word count", exp_data.size(), rx_data.size());
        for (int i = 0; i < exp_data.size() && i < rx_data.size(); i++) begin
            check_eq($sformatf("word %0d data", i), exp_data[i], rx_data[i]);
            check_eq($sformatf("word %0d first", i), exp_first[i], rx_first[i]);
        end
        exp_data.delete();
        exp_first.delete();
        rx_data.delete();
        rx_first.delete();
    endtask

    task automatic start_test(input string name);
        cur_test = name;
        test_errs = 0;
        fs_count = 0;
        tests_run++;
    endtask

    task automatic end_test();
        if (test_errs == 0) begin
            $display("test %s: ok", cur_test);
        end else begin
            $display("test %s: %0d errors", cur_test, test_errs);
        end
    endtask

    // ========================================
    // directed tests
    // ========================================

    task automatic test_clean_frame();
        start_test("clean_frame");
        check_eq("locked after reset", 0, o_frame_locked);
        check_eq("total after reset", 0, o_stats.total_frames);
        i_link_up = 1'b1;
        send_frame(32'h0001_0000, PAYLOAD_WORDS, 1'b0);
        wait_total(1);
        check_stream();
        check_eq("frame starts", 1, fs_count);
        check_eq("header", 32'h0001_0000, o_hdr);
        check_eq("frame index", 0, o_frame_index);
        check_eq("crc errors", 0, o_stats.crc_err_frames);
        check_eq("locked", 1, o_frame_locked);
        end_test();
    endtask

    task automatic test_bad_crc();
        start_test("bad_crc");
        i_link_up = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        i_link_up = 1'b1;
        check_eq("locked after link drop", 0, o_frame_locked);
        send_frame(32'h0002_0000, PAYLOAD_WORDS, 1'b1);
        wait_total(exp_total);
        check_eq("crc errors", exp_errs, o_stats.crc_err_frames);
        check_eq("locked after bad crc", 0, o_frame_locked);
        send_frame(32'h0002_0001, PAYLOAD_WORDS, 1'b0);
        wait_total(exp_total);
        check_eq("crc errors after good frame", exp_errs, o_stats.crc_err_frames);
        check_eq("locked after good crc", 1, o_frame_locked);
        check_stream();
        end_test();
    endtask

    task automatic test_hunt();
        word_t w;
        start_test("hunt");
        for (int i = 0; i < 4; i++) begin
            w = rand_word();
            send_word((w == PREAMBLE_HI) ? ~w : w);
        end
        send_word(PREAMBLE_HI);
        send_word(~PREAMBLE_LO);
        send_frame(32'h0003_0007, PAYLOAD_WORDS, 1'b0);
        wait_total(exp_total);
        repeat (4) @(posedge clk);
        #1;
        check_eq("total frames", exp_total, o_stats.total_frames);
        check_eq("header", 32'h0003_0007, o_hdr);
        check_stream();
        end_test();
    endtask

    task automatic test_back_pressure();
        start_test("back_pressure");
        for (int i = 0; i < 256; i++) begin
            bp_pat[i] = next_rand_bit();
        end
        bp_idx = 0;
        bp_en = 1'b1;
        send_frame(32'h0004_0000, PAYLOAD_WORDS, 1'b0);
        send_frame(32'h0004_0001, PAYLOAD_WORDS, 1'b0);
        wait_total(exp_total);
        bp_en = 1'b0;
        check_stream();
        check_eq("crc errors", exp_errs, o_stats.crc_err_frames);
        check_eq("frame index", hdr_count - 1, o_frame_index);
        check_eq("frame starts", 2, fs_count);
        end_test();
    endtask

    task automatic test_link_drop();
        start_test("link_drop");
        send_frame(32'h0005_0000, 5, 1'b0);
        i_link_up = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        check_eq("locked during drop", 0, o_frame_locked);
        check_eq("total after drop", exp_total, o_stats.total_frames);
        check_eq("crc errors after drop", exp_errs, o_stats.crc_err_frames);
        i_link_up = 1'b1;
        send_frame(32'h0005_0001, PAYLOAD_WORDS, 1'b0);
        wait_total(exp_total);
        check_stream();
        check_eq("frame index", hdr_count - 1, o_frame_index);
        check_eq("locked", 1, o_frame_locked);
        check_eq("frame starts", 2, fs_count);
        end_test();
    endtask

    initial begin
        rst_n = 1'b0;
        i_link_up = 1'b0;
        i_s_data = '0;
        i_s_valid = 1'b0;
        i_m_ready = 1'b1;
        lfsr_q = 32'h9297_0cd8;
        errors = 0;
        tests_run = 0;
        hdr_count = 0;
        exp_total = 0;
        exp_errs = 0;
        bp_en = 1'b0;
        bp_idx = 0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_clean_frame();
        test_bad_crc();
        test_hunt();
        test_back_pressure();
        test_link_drop();
        $display("tests run: %0d, errors: %0d", tests_run, errors);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* tb_fso_deframer_asserts.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_fso_deframer_asserts (
    input wire        clk,
    input wire        rst_n,
    input wire        i_link_up,
    input wire        o_s_ready,
    input wire [31:0] o_m_data,
    input wire        o_m_valid,
    input wire        i_m_ready,
    input wire        o_frame_start
);

    // held output word stays put until taken
    a_hold_data: assert property (@(posedge clk) disable iff (!rst_n)
        (o_m_valid && !i_m_ready) |=> (o_m_valid && $stable(o_m_data)))
        else $error("output word changed or dropped while downstream stalled");

    // no input accepted with the link down
    a_ready_link: assert property (@(posedge clk) disable iff (!rst_n)
        !i_link_up |-> !o_s_ready)
        else $error("o_s_ready high while link is down");

    a_start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        o_frame_start |=> !o_frame_start)
        else $error("o_frame_start longer than one cycle");

endmodule

bind fso_deframer tb_fso_deframer_asserts u_asserts (
    .clk           (clk),
    .rst_n         (rst_n),
    .i_link_up     (i_link_up),
    .o_s_ready     (o_s_ready),
    .o_m_data      (o_m_data),
    .o_m_valid     (o_m_valid),
    .i_m_ready     (i_m_ready),
    .o_frame_start (o_frame_start)
);

`default_nettype wire

/* fso_deframer.sv */
`timescale 1ns/1ps
`default_nettype none

module fso_deframer
    import dfr_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,
    input  wire            i_link_up,
    input  word_t          i_s_data,
    input  wire            i_s_valid,
    output logic           o_s_ready,
    output word_t          o_m_data,
    output logic           o_m_first,
    output logic           o_m_valid,
    input  wire            i_m_ready,
    output logic           o_frame_start,
    output frame_hdr_t     o_hdr,
    output logic [15:0]    o_frame_index,
    output logic           o_frame_locked,
    output frame_stats_t   o_stats
);

    sync_ev_t ev;
    word_t    acc_word;
    logic     crc_ok;
    logic     stall;

    // decode, crc check, result
    frame_sync u_sync (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_link_up (i_link_up),
        .i_s_data  (i_s_data),
        .i_s_valid (i_s_valid),
        .i_m_ready (i_m_ready),
        .i_stall   (stall),
        .o_s_ready (o_s_ready),
        .o_ev      (ev),
        .o_word    (acc_word)
    );

    crc32_check u_crc (
        .clk      (clk),
        .rst_n    (rst_n),
        .i_ev     (ev),
        .i_word   (acc_word),
        .o_crc_ok (crc_ok)
    );

    frame_result u_result (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_link_up      (i_link_up),
        .i_ev           (ev),
        .i_word         (acc_word),
        .i_crc_ok       (crc_ok),
        .i_m_ready      (i_m_ready),
        .o_stall        (stall),
        .o_m_data       (o_m_data),
        .o_m_first      (o_m_first),
        .o_m_valid      (o_m_valid),
        .o_frame_start  (o_frame_start),
        .o_hdr          (o_hdr),
        .o_frame_index  (o_frame_index),
        .o_frame_locked (o_frame_locked),
        .o_stats        (o_stats)
    );

endmodule

`default_nettype wire

/* frame_result.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_result
    import dfr_pkg::*;
(
    input  wire            clk,
    input  wire            rst_n,
    input  wire            i_link_up,
    input  sync_ev_t       i_ev,
    input  word_t          i_word,
    input  wire            i_crc_ok,
    input  wire            i_m_ready,
    output logic           o_stall,
    output word_t          o_m_data,
    output logic           o_m_first,
    output logic           o_m_valid,
    output logic           o_frame_start,
    output frame_hdr_t     o_hdr,
    output logic [15:0]    o_frame_index,
    output logic           o_frame_locked,
    output frame_stats_t   o_stats
);

    logic [15:0] frame_cnt;

    // held word not yet taken downstream
    assign o_stall = o_m_valid && !i_m_ready;

    // ========================================
    // payload output register
    // ========================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_m_valid     <= 1'b0;
            o_m_first     <= 1'b0;
            o_frame_start <= 1'b0;
        end else begin
            o_frame_start <= i_ev.pay_fire && i_ev.first_word;
            if (i_ev.pay_fire) begin
                o_m_valid <= 1'b1;
                o_m_first <= i_ev.first_word;
            end else if (o_m_valid && i_m_ready) begin
                o_m_valid <= 1'b0;
            end
        end
    end

    // payload word held for downstream
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_m_data <= '0;
        end else if (i_ev.pay_fire) begin
            o_m_data <= i_word;
        end
    end

    // ========================================
    // header, index, lock and counters
    // ========================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_hdr          <= '0;
            o_frame_index  <= '0;
            frame_cnt      <= '0;
            o_frame_locked <= 1'b0;
            o_stats        <= '0;
        end else begin
            if (i_ev.hdr_fire) begin
                o_hdr         <= frame_hdr_t'(i_word);
                o_frame_index <= frame_cnt;
                frame_cnt     <= frame_cnt + 1'b1;
            end

            if (i_ev.crc_fire) begin
                if (o_stats.total_frames != CNT_MAX) begin
                    o_stats.total_frames <= o_stats.total_frames + 1'b1;
                end
                if (!i_crc_ok && (o_stats.crc_err_frames != CNT_MAX)) begin
                    o_stats.crc_err_frames <= o_stats.crc_err_frames + 1'b1;
                end
            end

            // link loss wins over a good crc
            if (!i_link_up) begin
                o_frame_locked <= 1'b0;
            end else if (i_ev.crc_fire && i_crc_ok) begin
                o_frame_locked <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* crc32_check.sv */
`timescale 1ns/1ps
`default_nettype none

module crc32_check
    import dfr_pkg::*;
(
    input  wire         clk,
    input  wire         rst_n,
    input  sync_ev_t    i_ev,
    input  word_t       i_word,
    output logic        o_crc_ok
);

    logic [31:0] crc_q;

    // one full word through the serial crc, msb first
    function automatic logic [31:0] crc_word(input logic [31:0] crc_in,
                                             input word_t       data);
        logic [31:0] c;
        logic        fb;
        c = crc_in;
        for (int i = DATA_W - 1; i >= 0; i--) begin
            fb = c[31] ^ data[i];
            c  = {c[30:0], 1'b0};
            if (fb) begin
                c = c ^ CRC_POLY;
            end
        end
        return c;
    endfunction

    // ========================================
    // running crc over payload
    // ========================================

    // header reseeds, so the register is clean before word 0
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc_q <= CRC_INIT;
        end else if (i_ev.hdr_fire) begin
            crc_q <= CRC_INIT;
        end else if (i_ev.pay_fire) begin
            crc_q <= crc_word(crc_q, i_word);
        end
    end

    // only looked at while crc_fire is high
    assign o_crc_ok = (i_word == crc_q);

endmodule

`default_nettype wire

/* frame_sync.sv */
`timescale 1ns/1ps
`default_nettype none

module frame_sync
    import dfr_pkg::*;
(
    input  wire              clk,
    input  wire              rst_n,
    input  wire              i_link_up,
    input  word_t            i_s_data,
    input  wire              i_s_valid,
    input  wire              i_m_ready,
    input  wire              i_stall,
    output logic             o_s_ready,
    output sync_ev_t         o_ev,
    output word_t            o_word
);

    typedef enum logic [2:0] {
        S_WAIT_LINK = 3'd0,
        S_HUNT_HI   = 3'd1,
        S_HUNT_LO   = 3'd2,
        S_HEADER    = 3'd3,
        S_PAYLOAD   = 3'd4,
        S_CRC       = 3'd5
    } sync_state_t;

    sync_state_t          state;
    logic [PAY_CNT_W-1:0] pay_cnt;
    logic                 fire;
    logic                 last_pay;

    // ========================================
    // input handshake
    // ========================================

    // nothing is taken while the result register is stuck
    // payload words also need room downstream right now
    always_comb begin
        o_s_ready = 1'b0;
        if (i_link_up && !i_stall) begin
            case (state)
                S_WAIT_LINK: o_s_ready = 1'b0;
                S_PAYLOAD:   o_s_ready = i_m_ready;
                default:     o_s_ready = 1'b1;
            endcase
        end
    end

    assign fire     = i_s_valid && o_s_ready;
    assign last_pay = (pay_cnt == PAY_CNT_W'(PAYLOAD_WORDS - 1));
    assign o_word   = i_s_data;

    // event strobes for the later stages
    always_comb begin
        o_ev            = '0;
        o_ev.hdr_fire   = fire && (state == S_HEADER);
        o_ev.pay_fire   = fire && (state == S_PAYLOAD);
        o_ev.first_word = fire && (state == S_PAYLOAD) && (pay_cnt == '0);
        o_ev.crc_fire   = fire && (state == S_CRC);
    end

    // ========================================
    // frame FSM
    // ========================================

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_WAIT_LINK;
            pay_cnt <= '0;
        end else if (!i_link_up) begin
            // partial frame is dropped
            state   <= S_WAIT_LINK;
            pay_cnt <= '0;
        end else begin
            case (state)
                S_WAIT_LINK: begin
                    state <= S_HUNT_HI;
                end

                S_HUNT_HI: begin
                    if (fire && (i_s_data == PREAMBLE_HI)) begin
                        state <= S_HUNT_LO;
                    end
                end

                S_HUNT_LO: begin
                    if (fire) begin
                        // mismatch restarts the hunt, even on another HI word
                        state <= (i_s_data == PREAMBLE_LO) ? S_HEADER : S_HUNT_HI;
                    end
                end

                S_HEADER: begin
                    if (fire) begin
                        pay_cnt <= '0;
                        state   <= S_PAYLOAD;
                    end
                end

                S_PAYLOAD: begin
                    if (fire) begin
                        if (last_pay) begin
                            pay_cnt <= '0;
                            state   <= S_CRC;
                        end else begin
                            pay_cnt <= pay_cnt + 1'b1;
                        end
                    end
                end

                S_CRC: begin
                    if (fire) begin
                        state <= S_HUNT_HI;
                    end
                end

                default: begin
                    state <= S_WAIT_LINK;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* dfr_pkg.sv */
`default_nettype none

package dfr_pkg;

    // ========================================
    // stream and frame format
    // ========================================

    localparam int DATA_W        = 32;
    localparam int PAYLOAD_WORDS = 16;
    localparam int PAY_CNT_W     = 4;

    // two-word preamble, high word comes first on the link
    localparam logic [DATA_W-1:0] PREAMBLE_HI = 32'hEB94_BDA3;
    localparam logic [DATA_W-1:0] PREAMBLE_LO = 32'hF6AA_EE24;

    // ========================================
    // crc and statistics
    // ========================================

    // crc-32, msb first, no reflection, no final xor
    localparam logic [31:0] CRC_POLY = 32'h04C1_1DB7;
    localparam logic [31:0] CRC_INIT = 32'hFFFF_FFFF;

    // frame counters stop here
    localparam logic [31:0] CNT_MAX = 32'hFFFF_FFFF;

    // ========================================
    // shared types
    // ========================================

    typedef logic [DATA_W-1:0] word_t;

    // header word layout
    typedef struct packed {
        logic [15:0] block_id;
        logic [15:0] frame_in_block;
    } frame_hdr_t;

    // single-cycle strobes out of the decode stage
    typedef struct packed {
        logic hdr_fire;
        logic pay_fire;
        logic first_word;
        logic crc_fire;
    } sync_ev_t;

    typedef struct packed {
        logic [31:0] total_frames;
        logic [31:0] crc_err_frames;
    } frame_stats_t;

endpackage

`default_nettype wire
